// File: tb.f
soc_ifc_pkg.sv
soc_ifc_arb.sv
soc_ifc_fuse_bank.sv
soc_ifc_trng_bank.sv
soc_ifc_top.sv
soc_ifc_tb_sva.sv
soc_ifc_tb.sv

// File: Makefile
TOOL   := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := soc_ifc_tb
FLIST  := tb.f
OBJ    := obj_dir
LOG    := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

// File: soc_ifc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_tb;
    import soc_ifc_pkg::*;

    localparam logic SOC = 1'b0;
    localparam logic UC  = 1'b1;
    localparam logic RD  = 1'b0;
    localparam logic WR  = 1'b1;

    typedef struct packed {
        logic       uc;
        logic       write;
        addr_t      addr;
        data_t      wdata;
        user_t      user;
        logic [3:0] stall;
        logic       pair;
        data_t      exp_rdata;
        logic       exp_err;
        logic       exp_done;
    } entry_t;

    logic     clk;
    logic     cptra_noncore_rst_b;
    logic     soc_req_valid_i;
    logic     soc_req_ready_o;
    soc_req_t soc_req_i;
    logic     soc_resp_valid_o;
    logic     soc_resp_ready_i;
    resp_t    soc_resp_o;
    logic     uc_req_valid_i;
    logic     uc_req_ready_o;
    uc_req_t  uc_req_i;
    logic     uc_resp_valid_o;
    logic     uc_resp_ready_i;
    resp_t    uc_resp_o;
    logic     fuse_done_o;

    entry_t   table_q[$];
    int       seed = 32'h361b_d050;
    int       err_cnt;
    int       pass_cnt;
    int       fail_cnt;
    int       i;
    logic     table_done;

    // Reference register state
    data_t    m_fuse [FUSE_WORDS];
    data_t    m_trng [TRNG_WORDS];
    logic     m_done;
    logic     m_lock;
    user_t    m_user;

    soc_ifc_top DUT (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .soc_req_valid_i     (soc_req_valid_i),
        .soc_req_ready_o     (soc_req_ready_o),
        .soc_req_i           (soc_req_i),
        .soc_resp_valid_o    (soc_resp_valid_o),
        .soc_resp_ready_i    (soc_resp_ready_i),
        .soc_resp_o          (soc_resp_o),
        .uc_req_valid_i      (uc_req_valid_i),
        .uc_req_ready_o      (uc_req_ready_o),
        .uc_req_i            (uc_req_i),
        .uc_resp_valid_o     (uc_resp_valid_o),
        .uc_resp_ready_i     (uc_resp_ready_i),
        .uc_resp_o           (uc_resp_o),
        .fuse_done_o         (fuse_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model in service order
    ////////////////////////////////////////////////////////////////////////////
    function automatic void predict(inout entry_t e);
        int a;
        int idx;
        a = int'(e.addr);
        e.exp_err   = 1'b0;
        e.exp_rdata = '0;
        if (e.addr == FUSE_DONE_ADDR) begin
            e.exp_rdata = data_t'(m_done);
            if (e.write && e.wdata[0]) begin
                m_done = 1'b1;
            end
        end else if (a >= int'(FUSE_BASE_ADDR) && a < int'(FUSE_BASE_ADDR) + 4 * FUSE_WORDS) begin
            idx = (a - int'(FUSE_BASE_ADDR)) / 4;
            e.exp_rdata = m_fuse[idx];
            if (e.write && !m_done) begin
                m_fuse[idx] = e.wdata;
            end
        end else if (e.addr == VALID_USER_ADDR) begin
            e.exp_rdata = data_t'(m_user);
            if (e.write && !m_lock) begin
                m_user = e.wdata[USER_W-1:0];
            end
        end else if (e.addr == USER_LOCK_ADDR) begin
            e.exp_rdata = data_t'(m_lock);
            if (e.write && !m_lock) begin
                m_lock = e.wdata[0];
            end
        end else if (a >= int'(TRNG_BASE_ADDR) && a < int'(TRNG_BASE_ADDR) + 4 * TRNG_WORDS) begin
            idx = (a - int'(TRNG_BASE_ADDR)) / 4;
            e.exp_rdata = m_trng[idx];
            // Only the SoC under the registered user may load entropy
            if (e.write && !e.uc && e.user == m_user) begin
                m_trng[idx] = e.wdata;
            end
        end else begin
            e.exp_err = 1'b1;
        end
        e.exp_done = m_done;
    endfunction

    function automatic void add_access(input logic uc, input logic write, input addr_t addr,
                                       input data_t wdata, input user_t user, input int stall,
                                       input logic pair);
        entry_t e;
        e       = '0;
        e.uc    = uc;
        e.write = write;
        e.addr  = addr;
        e.wdata = wdata;
        e.user  = uc ? UC_USER : user;
        e.stall = 4'(stall);
        e.pair  = pair;
        predict(e);
        table_q.push_back(e);
    endfunction

    function automatic data_t rand_word();
        return $random(seed);
    endfunction

    task automatic build_table();
        m_done = 1'b0;
        m_lock = 1'b0;
        m_user = '0;
        for (int k = 0; k < FUSE_WORDS; k++) begin
            m_fuse[k] = '0;
        end
        for (int k = 0; k < TRNG_WORDS; k++) begin
            m_trng[k] = '0;
        end
        // Fuse words before done with some responses held back
        add_access(SOC, WR, 8'h04, rand_word(), 8'h10, 0, 1'b0);
        add_access(SOC, WR, 8'h08, rand_word(), 8'h10, 0, 1'b0);
        add_access(UC,  WR, 8'h20, rand_word(), 8'h00, 0, 1'b0);
        add_access(UC,  RD, 8'h04, '0, 8'h00, 0, 1'b0);
        add_access(SOC, RD, 8'h20, '0, 8'h10, 3, 1'b0);
        add_access(UC,  RD, 8'h08, '0, 8'h00, 5, 1'b0);
        // Unmapped space
        add_access(SOC, RD, 8'h3C, '0, 8'h10, 0, 1'b0);
        add_access(UC,  WR, 8'h40, 32'hdead_beef, 8'h00, 0, 1'b0);
        add_access(SOC, RD, 8'hFC, '0, 8'h10, 2, 1'b0);
        // Valid user then lock
        add_access(SOC, WR, VALID_USER_ADDR, 32'h0000_005A, 8'h10, 0, 1'b0);
        add_access(SOC, WR, USER_LOCK_ADDR, 32'h0000_0001, 8'h10, 0, 1'b0);
        add_access(SOC, WR, VALID_USER_ADDR, 32'h0000_0033, 8'h10, 0, 1'b0);
        add_access(UC,  RD, VALID_USER_ADDR, '0, 8'h00, 0, 1'b0);
        add_access(UC,  WR, USER_LOCK_ADDR, '0, 8'h00, 0, 1'b0);
        add_access(SOC, RD, USER_LOCK_ADDR, '0, 8'h10, 0, 1'b0);
        // Entropy writes from good and bad sources
        add_access(SOC, WR, 8'h2C, 32'h1111_0001, 8'h5A, 0, 1'b0);
        add_access(UC,  WR, 8'h2C, 32'h2222_0002, 8'h00, 0, 1'b0);
        add_access(SOC, WR, 8'h2C, 32'h3333_0003, 8'h11, 0, 1'b0);
        add_access(SOC, RD, 8'h2C, '0, 8'h11, 0, 1'b0);
        add_access(SOC, WR, 8'h38, 32'h4444_0004, 8'h5A, 2, 1'b0);
        add_access(UC,  RD, 8'h38, '0, 8'h00, 0, 1'b0);
        // On a tie the SoC wins since the uC went last
        add_access(SOC, RD, 8'h2C, '0, 8'h5A, 0, 1'b1);
        add_access(UC,  RD, 8'h04, '0, 8'h00, 0, 1'b0);
        add_access(SOC, WR, 8'h30, 32'h5555_0005, 8'h5A, 0, 1'b1);
        add_access(UC,  RD, 8'h30, '0, 8'h00, 0, 1'b0);
        // Fuse lock
        add_access(SOC, WR, FUSE_DONE_ADDR, 32'h0000_0001, 8'h10, 0, 1'b0);
        add_access(SOC, WR, 8'h04, rand_word(), 8'h10, 0, 1'b0);
        add_access(UC,  WR, 8'h20, rand_word(), 8'h00, 0, 1'b0);
        add_access(SOC, RD, 8'h04, '0, 8'h10, 0, 1'b0);
        add_access(UC,  RD, 8'h20, '0, 8'h00, 0, 1'b0);
        add_access(UC,  RD, FUSE_DONE_ADDR, '0, 8'h00, 0, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Channel access
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic req_ready(input logic uc);
        return uc ? uc_req_ready_o : soc_req_ready_o;
    endfunction

    function automatic logic resp_valid(input logic uc);
        return uc ? uc_resp_valid_o : soc_resp_valid_o;
    endfunction

    function automatic resp_t resp_seen(input logic uc);
        return uc ? uc_resp_o : soc_resp_o;
    endfunction

    task automatic drive_req(input entry_t e, input logic valid);
        if (e.uc) begin
            uc_req_i       = {e.write, e.addr, e.wdata};
            uc_req_valid_i = valid;
        end else begin
            soc_req_i       = {e.write, e.addr, e.wdata, e.user};
            soc_req_valid_i = valid;
        end
    endtask

    task automatic set_resp_ready(input logic uc, input logic ready);
        if (uc) begin
            uc_resp_ready_i = ready;
        end else begin
            soc_resp_ready_i = ready;
        end
    endtask

    task automatic run_access(input int idx);
        entry_t e;
        resp_t  got;
        int     lat;
        int     bad;
        e   = table_q[idx];
        lat = 0;
        bad = 0;
        set_resp_ready(e.uc, e.stall == 4'd0);
        drive_req(e, 1'b1);
        // Ready is sampled mid cycle away from the edge
        do begin
            @(negedge clk);
        end while (!req_ready(e.uc));
        @(posedge clk);
        #1;
        drive_req(e, 1'b0);
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid(e.uc));
        got = resp_seen(e.uc);
        repeat (e.stall) begin
            @(posedge clk);
            #1;
            if (!resp_valid(e.uc) || resp_seen(e.uc) !== got ||
                soc_req_ready_o || uc_req_ready_o) begin
                $display("ERROR %0t: entry %0d response moved or a request was ready during hold",
                         $time, idx);
                bad++;
            end
        end
        set_resp_ready(e.uc, 1'b1);
        @(posedge clk);
        #1;
        if (lat != 2) begin
            $display("ERROR %0t: entry %0d response came %0d cycles after accept, not 2",
                     $time, idx, lat);
            bad++;
        end
        if (got.rdata !== e.exp_rdata) begin
            $display("ERROR %0t: entry %0d rdata %h, expected %h", $time, idx, got.rdata,
                     e.exp_rdata);
            bad++;
        end
        if (got.error !== e.exp_err) begin
            $display("ERROR %0t: entry %0d error %b, expected %b", $time, idx, got.error,
                     e.exp_err);
            bad++;
        end
        if (fuse_done_o !== e.exp_done) begin
            $display("ERROR %0t: entry %0d fuse_done_o %b, expected %b", $time, idx,
                     fuse_done_o, e.exp_done);
            bad++;
        end
        err_cnt += bad;
        if (bad == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %0d: %s %s 0x%02h %s", idx, e.uc ? "uc " : "soc",
                 e.write ? "write" : "read ", e.addr, (bad == 0) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        cptra_noncore_rst_b = 1'b0;
        soc_req_valid_i     = 1'b0;
        soc_req_i           = '0;
        soc_resp_ready_i    = 1'b1;
        uc_req_valid_i      = 1'b0;
        uc_req_i            = '0;
        uc_resp_ready_i     = 1'b1;
        err_cnt             = 0;
        pass_cnt            = 0;
        fail_cnt            = 0;
        table_done          = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        cptra_noncore_rst_b = 1'b1;
        build_table();
        table_done = 1'b1;
        if (!soc_req_ready_o || !uc_req_ready_o || soc_resp_valid_o || uc_resp_valid_o ||
            fuse_done_o) begin
            $display("ERROR %0t: outputs after reset are not in the idle state", $time);
            err_cnt++;
        end
        i = 0;
        while (i < table_q.size()) begin
            if (table_q[i].pair) begin
                fork
                    run_access(i);
                    run_access(i + 1);
                join
                i += 2;
            end else begin
                run_access(i);
                i++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", pass_cnt + fail_cnt,
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_done);
        repeat (table_q.size() * 20) @(posedge clk);
        $display("Watchdog expired before all accesses completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_ifc_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_tb_sva (
    input wire                     clk,
    input wire                     cptra_noncore_rst_b,
    input wire                     soc_req_valid_i,
    input wire                     soc_req_ready_o,
    input soc_ifc_pkg::soc_req_t   soc_req_i,
    input wire                     soc_resp_valid_o,
    input wire                     uc_req_valid_i,
    input wire                     uc_req_ready_o,
    input soc_ifc_pkg::uc_req_t    uc_req_i,
    input wire                     uc_resp_valid_o
);

    // A waiting request keeps valid and payload
    soc_req_hold: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        soc_req_valid_i && !soc_req_ready_o |=> soc_req_valid_i && $stable(soc_req_i))
        else $error("SoC request dropped or changed before transfer");

    uc_req_hold: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        uc_req_valid_i && !uc_req_ready_o |=> uc_req_valid_i && $stable(uc_req_i))
        else $error("uC request dropped or changed before transfer");

    ////////////////////////////////////////////////////////////////////////////
    // Response follows one access cycle
    ////////////////////////////////////////////////////////////////////////////
    soc_resp_lat: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        soc_req_valid_i && soc_req_ready_o |=> !soc_resp_valid_o ##1 soc_resp_valid_o)
        else $error("SoC response not valid two cycles after accept");

    uc_resp_lat: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        uc_req_valid_i && uc_req_ready_o |=> !uc_resp_valid_o ##1 uc_resp_valid_o)
        else $error("uC response not valid two cycles after accept");

    resp_onehot: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        !(soc_resp_valid_o && uc_resp_valid_o))
        else $error("Both response channels valid at once");

endmodule

bind soc_ifc_top soc_ifc_tb_sva u_soc_ifc_tb_sva (
    .clk                 (clk),
    .cptra_noncore_rst_b (cptra_noncore_rst_b),
    .soc_req_valid_i     (soc_req_valid_i),
    .soc_req_ready_o     (soc_req_ready_o),
    .soc_req_i           (soc_req_i),
    .soc_resp_valid_o    (soc_resp_valid_o),
    .uc_req_valid_i      (uc_req_valid_i),
    .uc_req_ready_o      (uc_req_ready_o),
    .uc_req_i            (uc_req_i),
    .uc_resp_valid_o     (uc_resp_valid_o)
);

`default_nettype wire

// File: soc_ifc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_top (
    input  wire                       clk,
    input  wire                       cptra_noncore_rst_b,

    input  wire                       soc_req_valid_i,
    output logic                      soc_req_ready_o,
    input  soc_ifc_pkg::soc_req_t     soc_req_i,
    output logic                      soc_resp_valid_o,
    input  wire                       soc_resp_ready_i,
    output soc_ifc_pkg::resp_t        soc_resp_o,

    input  wire                       uc_req_valid_i,
    output logic                      uc_req_ready_o,
    input  soc_ifc_pkg::uc_req_t      uc_req_i,
    output logic                      uc_resp_valid_o,
    input  wire                       uc_resp_ready_i,
    output soc_ifc_pkg::resp_t        uc_resp_o,

    output logic                      fuse_done_o
);
    import soc_ifc_pkg::*;

    bank_req_t  bank_req;
    logic       bank_access;
    bank_resp_t fuse_resp;
    bank_resp_t trng_resp;

    ////////////////////////////////////////////////////////////////////////////
    // Requester arbitration
    ////////////////////////////////////////////////////////////////////////////
    soc_ifc_arb i_soc_ifc_arb (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .soc_req_valid_i     (soc_req_valid_i),
        .soc_req_ready_o     (soc_req_ready_o),
        .soc_req_i           (soc_req_i),
        .soc_resp_valid_o    (soc_resp_valid_o),
        .soc_resp_ready_i    (soc_resp_ready_i),
        .soc_resp_o          (soc_resp_o),
        .uc_req_valid_i      (uc_req_valid_i),
        .uc_req_ready_o      (uc_req_ready_o),
        .uc_req_i            (uc_req_i),
        .uc_resp_valid_o     (uc_resp_valid_o),
        .uc_resp_ready_i     (uc_resp_ready_i),
        .uc_resp_o           (uc_resp_o),
        .bank_req_o          (bank_req),
        .bank_access_o       (bank_access),
        .fuse_resp_i         (fuse_resp),
        .trng_resp_i         (trng_resp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Register banks
    ////////////////////////////////////////////////////////////////////////////
    soc_ifc_fuse_bank i_soc_ifc_fuse_bank (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .bank_req_i          (bank_req),
        .bank_access_i       (bank_access),
        .bank_resp_o         (fuse_resp),
        .fuse_done_o         (fuse_done_o)
    );

    soc_ifc_trng_bank i_soc_ifc_trng_bank (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .bank_req_i          (bank_req),
        .bank_access_i       (bank_access),
        .bank_resp_o         (trng_resp)
    );

endmodule

`default_nettype wire

// File: soc_ifc_trng_bank.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_trng_bank (
    input  wire                       clk,
    input  wire                       cptra_noncore_rst_b,
    input  soc_ifc_pkg::bank_req_t    bank_req_i,
    input  wire                       bank_access_i,
    output soc_ifc_pkg::bank_resp_t   bank_resp_o
);
    import soc_ifc_pkg::*;

    user_t                 valid_user_q;
    logic                  user_lock_q;
    data_t                 trng_q [TRNG_WORDS];
    addr_t                 trng_off;
    logic [TRNG_IDX_W-1:0] trng_idx;
    logic                  user_hit;
    logic                  lock_hit;
    logic                  trng_hit;
    logic                  user_ok;
    logic                  wr_en;

    assign user_hit = (bank_req_i.addr == VALID_USER_ADDR);
    assign lock_hit = (bank_req_i.addr == USER_LOCK_ADDR);

    assign trng_off = bank_req_i.addr - TRNG_BASE_ADDR;
    assign trng_idx = trng_off[TRNG_IDX_W+1:2];
    assign trng_hit = (trng_off[1:0] == 2'b00) &&
                      (trng_off[ADDR_W-1:TRNG_IDX_W+2] == '0);

    // Entropy is writable only by the SoC under the registered user
    assign user_ok = bank_req_i.soc_req && (bank_req_i.user == valid_user_q);
    assign wr_en   = bank_access_i & bank_req_i.write;

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            valid_user_q <= '0;
            user_lock_q  <= 1'b0;
            for (int i = 0; i < TRNG_WORDS; i++) begin
                trng_q[i] <= '0;
            end
        end else begin
            // Lock freezes both the user and itself
            if (wr_en && !user_lock_q) begin
                if (user_hit) begin
                    valid_user_q <= bank_req_i.wdata[USER_W-1:0];
                end
                if (lock_hit) begin
                    user_lock_q <= bank_req_i.wdata[0];
                end
            end
            if (wr_en && trng_hit && user_ok) begin
                trng_q[trng_idx] <= bank_req_i.wdata;
            end
        end
    end

    // Every address of this bank reads back
    always_comb begin
        bank_resp_o.hit   = user_hit | lock_hit | trng_hit;
        bank_resp_o.rdata = '0;
        if (user_hit) begin
            bank_resp_o.rdata = data_t'(valid_user_q);
        end else if (lock_hit) begin
            bank_resp_o.rdata = data_t'(user_lock_q);
        end else if (trng_hit) begin
            bank_resp_o.rdata = trng_q[trng_idx];
        end
    end

endmodule

`default_nettype wire

// File: soc_ifc_fuse_bank.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_fuse_bank (
    input  wire                       clk,
    input  wire                       cptra_noncore_rst_b,
    input  soc_ifc_pkg::bank_req_t    bank_req_i,
    input  wire                       bank_access_i,
    output soc_ifc_pkg::bank_resp_t   bank_resp_o,
    output logic                      fuse_done_o
);
    import soc_ifc_pkg::*;

    data_t                 fuse_q [FUSE_WORDS];
    logic                  fuse_done_q;
    addr_t                 fuse_off;
    logic [FUSE_IDX_W-1:0] fuse_idx;
    logic                  done_hit;
    logic                  fuse_hit;
    logic                  wr_en;

    // Word aligned and inside the fuse window
    assign fuse_off = bank_req_i.addr - FUSE_BASE_ADDR;
    assign fuse_idx = fuse_off[FUSE_IDX_W+1:2];
    assign fuse_hit = (fuse_off[1:0] == 2'b00) &&
                      (fuse_off[ADDR_W-1:FUSE_IDX_W+2] == '0);
    assign done_hit = (bank_req_i.addr == FUSE_DONE_ADDR);

    assign wr_en = bank_access_i & bank_req_i.write;

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            fuse_done_q <= 1'b0;
            for (int i = 0; i < FUSE_WORDS; i++) begin
                fuse_q[i] <= '0;
            end
        end else begin
            // Done is sticky until the next reset
            if (wr_en && done_hit && bank_req_i.wdata[0]) begin
                fuse_done_q <= 1'b1;
            end
            // Locked fuse writes are dropped without an error
            if (wr_en && fuse_hit && !fuse_done_q) begin
                fuse_q[fuse_idx] <= bank_req_i.wdata;
            end
        end
    end

    always_comb begin
        bank_resp_o.hit   = 1'b0;
        bank_resp_o.rdata = '0;
        if (done_hit) begin
            bank_resp_o.hit   = 1'b1;
            bank_resp_o.rdata = data_t'(fuse_done_q);
        end else if (fuse_hit) begin
            bank_resp_o.hit   = 1'b1;
            bank_resp_o.rdata = fuse_q[fuse_idx];
        end
    end

    assign fuse_done_o = fuse_done_q;

endmodule

`default_nettype wire

// File: soc_ifc_arb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_arb (
    input  wire                       clk,
    input  wire                       cptra_noncore_rst_b,

    input  wire                       soc_req_valid_i,
    output logic                      soc_req_ready_o,
    input  soc_ifc_pkg::soc_req_t     soc_req_i,
    output logic                      soc_resp_valid_o,
    input  wire                       soc_resp_ready_i,
    output soc_ifc_pkg::resp_t        soc_resp_o,

    input  wire                       uc_req_valid_i,
    output logic                      uc_req_ready_o,
    input  soc_ifc_pkg::uc_req_t      uc_req_i,
    output logic                      uc_resp_valid_o,
    input  wire                       uc_resp_ready_i,
    output soc_ifc_pkg::resp_t        uc_resp_o,

    output soc_ifc_pkg::bank_req_t    bank_req_o,
    output logic                      bank_access_o,
    input  soc_ifc_pkg::bank_resp_t   fuse_resp_i,
    input  soc_ifc_pkg::bank_resp_t   trng_resp_i
);
    import soc_ifc_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    // Set when the microcontroller holds the current or most recent grant
    logic       gnt_uc_q;
    logic       tie;
    logic       soc_go;
    logic       uc_go;
    logic       resp_done;
    resp_t      resp_q;

    ////////////////////////////////////////////////////////////////////////////
    // Round robin grant
    ////////////////////////////////////////////////////////////////////////////
    // On a tie only the side that was not granted last sees ready
    assign tie             = soc_req_valid_i & uc_req_valid_i;
    assign soc_req_ready_o = (state_q == ARB_IDLE) & ~(tie & ~gnt_uc_q);
    assign uc_req_ready_o  = (state_q == ARB_IDLE) & ~(tie & gnt_uc_q);

    assign soc_go = soc_req_valid_i & soc_req_ready_o;
    assign uc_go  = uc_req_valid_i & uc_req_ready_o;

    ////////////////////////////////////////////////////////////////////////////
    // Access sequencing
    ////////////////////////////////////////////////////////////////////////////
    assign resp_done = (soc_resp_valid_o & soc_resp_ready_i) |
                       (uc_resp_valid_o & uc_resp_ready_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (soc_go | uc_go) begin
                    state_d = ARB_ACCESS;
                end
            end
            ARB_ACCESS: state_d = ARB_RESP;
            ARB_RESP: begin
                if (resp_done) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            state_q  <= ARB_IDLE;
            gnt_uc_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (soc_go) begin
                gnt_uc_q <= 1'b0;
            end else if (uc_go) begin
                gnt_uc_q <= 1'b1;
            end
        end
    end

    // Latch the winner and flag which side issued it
    always_ff @(posedge clk) begin
        if (soc_go) begin
            bank_req_o.write   <= soc_req_i.write;
            bank_req_o.soc_req <= 1'b1;
            bank_req_o.addr    <= soc_req_i.addr;
            bank_req_o.wdata   <= soc_req_i.wdata;
            bank_req_o.user    <= soc_req_i.user;
        end else if (uc_go) begin
            bank_req_o.write   <= uc_req_i.write;
            bank_req_o.soc_req <= 1'b0;
            bank_req_o.addr    <= uc_req_i.addr;
            bank_req_o.wdata   <= uc_req_i.wdata;
            bank_req_o.user    <= UC_USER;
        end
    end

    assign bank_access_o = (state_q == ARB_ACCESS);

    // A miss in both banks is an error
    always_ff @(posedge clk) begin
        if (state_q == ARB_ACCESS) begin
            resp_q.error <= ~(fuse_resp_i.hit | trng_resp_i.hit);
            if (fuse_resp_i.hit) begin
                resp_q.rdata <= fuse_resp_i.rdata;
            end else if (trng_resp_i.hit) begin
                resp_q.rdata <= trng_resp_i.rdata;
            end else begin
                resp_q.rdata <= '0;
            end
        end
    end

    assign soc_resp_valid_o = (state_q == ARB_RESP) & ~gnt_uc_q;
    assign uc_resp_valid_o  = (state_q == ARB_RESP) & gnt_uc_q;
    assign soc_resp_o       = resp_q;
    assign uc_resp_o        = resp_q;

endmodule

`default_nettype wire

// File: soc_ifc_pkg.sv
`default_nettype none

package soc_ifc_pkg;

    // Bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int USER_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [USER_W-1:0] user_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////
    localparam addr_t FUSE_DONE_ADDR  = 8'h00;
    localparam addr_t FUSE_BASE_ADDR  = 8'h04;
    localparam int    FUSE_WORDS      = 8;
    localparam int    FUSE_IDX_W      = $clog2(FUSE_WORDS);
    localparam addr_t VALID_USER_ADDR = 8'h24;
    localparam addr_t USER_LOCK_ADDR  = 8'h28;
    localparam addr_t TRNG_BASE_ADDR  = 8'h2C;
    localparam int    TRNG_WORDS      = 4;
    localparam int    TRNG_IDX_W      = $clog2(TRNG_WORDS);

    // Microcontroller requests carry no user, so they get this one
    localparam user_t UC_USER = '1;

    ////////////////////////////////////////////////////////////////////////////
    // Request and response payloads
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        user_t user;
    } soc_req_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
    } uc_req_t;

    typedef struct packed {
        data_t rdata;
        logic  error;
    } resp_t;

    typedef struct packed {
        logic  write;
        logic  soc_req;
        addr_t addr;
        data_t wdata;
        user_t user;
    } bank_req_t;

    typedef struct packed {
        logic  hit;
        data_t rdata;
    } bank_resp_t;

    typedef enum logic [1:0] {
        ARB_IDLE   = 2'b00,
        ARB_ACCESS = 2'b01,
        ARB_RESP   = 2'b10
    } arb_state_t;

endpackage

`default_nettype wire
